//--- hdl/pcie_core_config.svh
// PCIe endpoint application core configuration
// widths, RAM depth, tag count and register offsets shared by design and testbench
`ifndef PCIE_CORE_CONFIG_SVH
`define PCIE_CORE_CONFIG_SVH

// dword width
`define DATA_W      32
// RAM dword address width, RAM depth is 2**RAM_AW dwords
`define RAM_AW      8
// BAR dword address width, top bit selects the register block
`define BAR_AW      9
`define HOST_AW     30
`define TAG_W       3
// most reads in flight at once
`define TAG_COUNT   8

// DMA register offsets inside the register block
`define REG_SRC     0
`define REG_DST     1
`define REG_LEN     2
`define REG_CTRL    3

`endif

//--- hdl/pcie_core_pkg.sv
// PCIe endpoint application core types
// width typedefs, stream payload structs and FSM state encodings
`default_nettype none

`include "pcie_core_config.svh"

package pcie_core_pkg;

    typedef logic [`DATA_W-1:0]  data_t;
    typedef logic [`RAM_AW-1:0]  ram_addr_t;
    typedef logic [`BAR_AW-1:0]  bar_addr_t;
    typedef logic [`HOST_AW-1:0] host_addr_t;
    typedef logic [`TAG_W-1:0]   tag_t;
    // one extra bit so a full RAM worth of dwords fits
    typedef logic [`RAM_AW:0]    len_t;

    typedef enum logic {CQ_READ, CQ_WRITE} cq_op_e;

    typedef enum logic [1:0] {IDLE, MEM_WAIT, CPL_SEND} cpl_state_e;

    typedef enum logic [1:0] {DMA_IDLE, DMA_ISSUE, DMA_DRAIN} dma_state_e;

    // host request on the completer side
    typedef struct packed {
        cq_op_e    op;
        bar_addr_t addr;
        data_t     data;
        tag_t      tag;
    } cq_req_t;

    typedef struct packed {
        tag_t  tag;
        data_t data;
    } cc_cpl_t;

    // read request from the DMA engine
    typedef struct packed {
        tag_t       tag;
        host_addr_t addr;
    } rq_req_t;

    typedef struct packed {
        tag_t  tag;
        data_t data;
    } rc_cpl_t;

    typedef struct packed {
        logic      we;
        ram_addr_t addr;
        data_t     wdata;
    } mem_req_t;

    typedef struct packed {
        host_addr_t src;
        ram_addr_t  dst;
        len_t       len;
    } dma_cmd_t;

endpackage

`default_nettype wire

//--- hdl/bar_ram.sv
// BAR memory
// single-port dword RAM shared by completer and DMA engine,
// write-first with one cycle of read latency
`timescale 1ns/1ps
`default_nettype none

module bar_ram
    import pcie_core_pkg::*;
(
    input  wire       clk,
    input  wire logic we,
    input  ram_addr_t addr,
    input  data_t     wdata,
    output data_t     rdata
);

    localparam int DEPTH = 2 ** $bits(ram_addr_t);

    data_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
            // a write returns the new word on the read port
            rdata <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- hdl/mem_arbiter.sv
// RAM arbiter
// round-robin between the completer (port 0) and the DMA engine (port 1),
// muxes the winner onto the RAM port and routes read-data valid back
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
    import pcie_core_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  mem_req_t   cpl_req,
    input  mem_req_t   dma_req,
    input  wire logic  cpl_valid,
    input  wire logic  dma_valid,
    output logic       cpl_grant,
    output logic       dma_grant,
    output logic       cpl_rdata_valid,
    output logic       dma_rdata_valid,
    output logic       ram_we,
    output ram_addr_t  ram_addr,
    output data_t      ram_wdata
);

    // set when the engine won the last grant
    logic last_dma;

    // completer wins when alone or when the engine went last
    assign cpl_grant = cpl_valid && (!dma_valid || last_dma);
    assign dma_grant = dma_valid && !cpl_grant;

    assign ram_we    = (cpl_grant && cpl_req.we) || (dma_grant && dma_req.we);
    assign ram_addr  = dma_grant ? dma_req.addr : cpl_req.addr;
    assign ram_wdata = dma_grant ? dma_req.wdata : cpl_req.wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_dma        <= 1'b1;
            cpl_rdata_valid <= 1'b0;
            dma_rdata_valid <= 1'b0;
        end else begin
            if (dma_grant) begin
                last_dma <= 1'b1;
            end else if (cpl_grant) begin
                last_dma <= 1'b0;
            end
            // read data shows up one cycle after the grant
            cpl_rdata_valid <= cpl_grant && !cpl_req.we;
            dma_rdata_valid <= dma_grant && !dma_req.we;
        end
    end

endmodule

`default_nettype wire

//--- hdl/cq_completer.sv
// Completer
// accepts host requests on the BAR, serves RAM and the DMA register block,
// returns one completion per read
`timescale 1ns/1ps
`default_nettype none

`include "pcie_core_config.svh"

module cq_completer
    import pcie_core_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  cq_req_t    cq_req,
    input  wire logic  cq_valid,
    output logic       cq_ready,
    output cc_cpl_t    cc_cpl,
    output logic       cc_valid,
    input  wire logic  cc_ready,
    output mem_req_t   mem_req,
    output logic       mem_valid,
    input  wire logic  mem_grant,
    input  wire logic  mem_rdata_valid,
    input  data_t      mem_rdata,
    output dma_cmd_t   dma_cmd,
    output logic       dma_start,
    input  wire logic  dma_busy
);

    cpl_state_e state;
    cq_req_t    cq_lat;
    data_t      cpl_data;
    dma_cmd_t   cmd_reg;
    data_t      reg_rdata;
    ram_addr_t  reg_off;
    logic       is_reg;
    logic       granted;

    assign is_reg  = cq_req.addr[`BAR_AW-1];
    assign reg_off = cq_req.addr[`RAM_AW-1:0];

    // register readback, CTRL bit 0 shows the engine busy flag
    always_comb begin
        case (reg_off)
            ram_addr_t'(`REG_SRC):  reg_rdata = data_t'(cmd_reg.src);
            ram_addr_t'(`REG_DST):  reg_rdata = data_t'(cmd_reg.dst);
            ram_addr_t'(`REG_LEN):  reg_rdata = data_t'(cmd_reg.len);
            ram_addr_t'(`REG_CTRL): reg_rdata = data_t'(dma_busy);
            default:                reg_rdata = '0;
        endcase
    end

    assign cq_ready = (state == IDLE);
    assign cc_valid = (state == CPL_SEND);
    assign cc_cpl.tag  = cq_lat.tag;
    assign cc_cpl.data = cpl_data;

    // RAM access for the latched request, dropped once granted
    assign mem_valid     = (state == MEM_WAIT) && !granted;
    assign mem_req.we    = (cq_lat.op == CQ_WRITE);
    assign mem_req.addr  = cq_lat.addr[`RAM_AW-1:0];
    assign mem_req.wdata = cq_lat.data;

    assign dma_cmd = cmd_reg;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            granted   <= 1'b0;
            dma_start <= 1'b0;
            cmd_reg   <= '0;
        end else begin
            dma_start <= 1'b0;
            case (state)
                IDLE: begin
                    granted <= 1'b0;
                    if (cq_valid && is_reg) begin
                        if (cq_req.op == CQ_WRITE) begin
                            case (reg_off)
                                ram_addr_t'(`REG_SRC): cmd_reg.src <= cq_req.data[`HOST_AW-1:0];
                                ram_addr_t'(`REG_DST): cmd_reg.dst <= cq_req.data[`RAM_AW-1:0];
                                ram_addr_t'(`REG_LEN): cmd_reg.len <= cq_req.data[`RAM_AW:0];
                                ram_addr_t'(`REG_CTRL): dma_start <= cq_req.data[0] && !dma_busy;
                                default: ;
                            endcase
                        end else begin
                            state <= CPL_SEND;
                        end
                    end else if (cq_valid) begin
                        state <= MEM_WAIT;
                    end
                end
                MEM_WAIT: begin
                    if (mem_grant) begin
                        // writes are posted and end on the grant
                        if (cq_lat.op == CQ_WRITE) begin
                            state <= IDLE;
                        end else begin
                            granted <= 1'b1;
                        end
                    end else if (mem_rdata_valid) begin
                        state <= CPL_SEND;
                    end
                end
                CPL_SEND: begin
                    if (cc_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && cq_valid) begin
            cq_lat   <= cq_req;
            cpl_data <= reg_rdata;
        end else if (state == MEM_WAIT && mem_rdata_valid) begin
            cpl_data <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

//--- hdl/dma_read_engine.sv
// DMA read engine
// splits a transfer into tagged single-dword reads toward the host and
// writes each returned completion into the BAR RAM
`timescale 1ns/1ps
`default_nettype none

`include "pcie_core_config.svh"

module dma_read_engine
    import pcie_core_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  dma_cmd_t   dma_cmd,
    input  wire logic  dma_start,
    output logic       dma_busy,
    output rq_req_t    rq_req,
    output logic       rq_valid,
    input  wire logic  rq_ready,
    input  rc_cpl_t    rc_cpl,
    input  wire logic  rc_valid,
    output logic       rc_ready,
    output mem_req_t   mem_req,
    output logic       mem_valid,
    input  wire logic  mem_grant,
    output logic       status_error_uncor
);

    dma_state_e state;
    dma_cmd_t   cmd_lat;
    len_t       issue_cnt;
    len_t       done_cnt;
    len_t       out_cnt;
    tag_t       next_tag;

    // per-tag table
    logic [`TAG_COUNT-1:0] tag_vld;
    ram_addr_t             dst_tab [`TAG_COUNT];

    // completion waiting for its RAM write
    logic      pend_vld;
    tag_t      pend_tag;
    ram_addr_t pend_addr;
    data_t     pend_data;

    logic rq_fire;
    logic rc_fire;
    logic wr_done;
    logic tag_hit;

    // issued but not yet written to RAM
    assign out_cnt = issue_cnt - done_cnt;

    assign dma_busy = (state != DMA_IDLE);

    // tags go out in order, stall while the next one is still in flight
    assign rq_valid    = (state == DMA_ISSUE) && (issue_cnt != cmd_lat.len) &&
                         !tag_vld[next_tag];
    assign rq_req.tag  = next_tag;
    assign rq_req.addr = cmd_lat.src + host_addr_t'(issue_cnt);
    assign rq_fire     = rq_valid && rq_ready;

    assign rc_ready = !pend_vld;
    assign rc_fire  = rc_valid && rc_ready;
    assign tag_hit  = tag_vld[rc_cpl.tag];

    assign mem_valid     = pend_vld;
    assign mem_req.we    = 1'b1;
    assign mem_req.addr  = pend_addr;
    assign mem_req.wdata = pend_data;
    assign wr_done       = pend_vld && mem_grant;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state              <= DMA_IDLE;
            issue_cnt          <= '0;
            done_cnt           <= '0;
            next_tag           <= '0;
            tag_vld            <= '0;
            pend_vld           <= 1'b0;
            status_error_uncor <= 1'b0;
        end else begin
            case (state)
                DMA_IDLE: begin
                    if (dma_start) begin
                        state     <= DMA_ISSUE;
                        issue_cnt <= '0;
                        done_cnt  <= '0;
                    end
                end
                DMA_ISSUE: begin
                    if (issue_cnt == cmd_lat.len) begin
                        state <= DMA_DRAIN;
                    end
                end
                DMA_DRAIN: begin
                    if (out_cnt == '0 || (wr_done && out_cnt == len_t'(1))) begin
                        state <= DMA_IDLE;
                    end
                end
                default: state <= DMA_IDLE;
            endcase

            if (rq_fire) begin
                issue_cnt         <= issue_cnt + 1'b1;
                next_tag          <= next_tag + 1'b1;
                tag_vld[next_tag] <= 1'b1;
            end

            // tag stays allocated until its dword is in RAM
            if (wr_done) begin
                pend_vld          <= 1'b0;
                done_cnt          <= done_cnt + 1'b1;
                tag_vld[pend_tag] <= 1'b0;
            end

            if (rc_fire && tag_hit) begin
                pend_vld <= 1'b1;
            end
            // unknown tag is consumed and flagged
            status_error_uncor <= rc_fire && !tag_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (state == DMA_IDLE && dma_start) begin
            cmd_lat <= dma_cmd;
        end
        if (rq_fire) begin
            dst_tab[next_tag] <= cmd_lat.dst + issue_cnt[`RAM_AW-1:0];
        end
        if (rc_fire && tag_hit) begin
            pend_tag  <= rc_cpl.tag;
            pend_addr <= dst_tab[rc_cpl.tag];
            pend_data <= rc_cpl.data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/pcie_core.sv
// PCIe endpoint application core
// completer and DMA read engine sharing one BAR RAM through an arbiter
`timescale 1ns/1ps
`default_nettype none

module pcie_core
    import pcie_core_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  cq_req_t    cq_req,
    input  wire logic  cq_valid,
    output logic       cq_ready,
    output cc_cpl_t    cc_cpl,
    output logic       cc_valid,
    input  wire logic  cc_ready,
    output rq_req_t    rq_req,
    output logic       rq_valid,
    input  wire logic  rq_ready,
    input  rc_cpl_t    rc_cpl,
    input  wire logic  rc_valid,
    output logic       rc_ready,
    output logic       dma_busy,
    output logic       status_error_uncor
);

    mem_req_t  cpl_mem_req;
    logic      cpl_mem_valid;
    logic      cpl_grant;
    logic      cpl_rdata_valid;
    mem_req_t  dma_mem_req;
    logic      dma_mem_valid;
    logic      dma_grant;
    logic      ram_we;
    ram_addr_t ram_addr;
    data_t     ram_wdata;
    data_t     ram_rdata;
    dma_cmd_t  dma_cmd;
    logic      dma_start;

    cq_completer cq_completer_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .cq_req          (cq_req),
        .cq_valid        (cq_valid),
        .cq_ready        (cq_ready),
        .cc_cpl          (cc_cpl),
        .cc_valid        (cc_valid),
        .cc_ready        (cc_ready),
        .mem_req         (cpl_mem_req),
        .mem_valid       (cpl_mem_valid),
        .mem_grant       (cpl_grant),
        .mem_rdata_valid (cpl_rdata_valid),
        .mem_rdata       (ram_rdata),
        .dma_cmd         (dma_cmd),
        .dma_start       (dma_start),
        .dma_busy        (dma_busy)
    );

    dma_read_engine dma_read_engine_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .dma_cmd            (dma_cmd),
        .dma_start          (dma_start),
        .dma_busy           (dma_busy),
        .rq_req             (rq_req),
        .rq_valid           (rq_valid),
        .rq_ready           (rq_ready),
        .rc_cpl             (rc_cpl),
        .rc_valid           (rc_valid),
        .rc_ready           (rc_ready),
        .mem_req            (dma_mem_req),
        .mem_valid          (dma_mem_valid),
        .mem_grant          (dma_grant),
        .status_error_uncor (status_error_uncor)
    );

    // the engine only writes, so its read-data valid stays open
    mem_arbiter mem_arbiter_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .cpl_req         (cpl_mem_req),
        .dma_req         (dma_mem_req),
        .cpl_valid       (cpl_mem_valid),
        .dma_valid       (dma_mem_valid),
        .cpl_grant       (cpl_grant),
        .dma_grant       (dma_grant),
        .cpl_rdata_valid (cpl_rdata_valid),
        .dma_rdata_valid (),
        .ram_we          (ram_we),
        .ram_addr        (ram_addr),
        .ram_wdata       (ram_wdata)
    );

    bar_ram bar_ram_inst (
        .clk   (clk),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

//--- verification/pcie_core_sva.sv
// Assertions for the DMA read engine
// rq handshake stability, tag accounting and busy release
`timescale 1ns/1ps
`default_nettype none

`include "pcie_core_config.svh"

module pcie_core_sva
    import pcie_core_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  rq_req_t    rq_req,
    input  wire logic  rq_valid,
    input  wire logic  rq_ready,
    input  wire logic  dma_busy,
    input  len_t       out_cnt,
    input  len_t       issue_cnt,
    input  len_t       len
);

    int unsigned fail_count = 0;
    logic        all_done;

    // nothing in flight and nothing left to issue
    assign all_done = dma_busy && (out_cnt == '0) && (issue_cnt == len);

    // stalled request keeps its payload
    assert property (@(posedge clk) disable iff (!rst_n)
        rq_valid && !rq_ready |=> rq_valid && $stable(rq_req))
    else begin
        $error("rq request changed while stalled");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        out_cnt <= len_t'(`TAG_COUNT))
    else begin
        $error("more reads outstanding than tags");
        fail_count++;
    end

    // ISSUE goes through DRAIN, so busy drops within two cycles
    assert property (@(posedge clk) disable iff (!rst_n)
        $past(all_done, 2) |-> !dma_busy)
    else begin
        $error("dma_busy held with no work left");
        fail_count++;
    end

endmodule

bind dma_read_engine pcie_core_sva pcie_core_sva_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .rq_req    (rq_req),
    .rq_valid  (rq_valid),
    .rq_ready  (rq_ready),
    .dma_busy  (dma_busy),
    .out_cnt   (out_cnt),
    .issue_cnt (issue_cnt),
    .len       (cmd_lat.len)
);

`default_nettype wire

//--- verification/tb_pcie_core.sv
// Testbench for the PCIe endpoint application core
// host model on rq/rc, MMIO traffic on cq, in-order completion checker on cc
`timescale 1ns/1ps
`default_nettype none

`include "pcie_core_config.svh"

module tb_pcie_core
    import pcie_core_pkg::*;
();

    localparam int SEED = 32'h45e2_42f5;
    localparam int WAIT_LIMIT = 4000;

    logic    clk;
    logic    rst_n;
    cq_req_t cq_req;
    logic    cq_valid;
    logic    cq_ready;
    cc_cpl_t cc_cpl;
    logic    cc_valid;
    logic    cc_ready;
    rq_req_t rq_req;
    logic    rq_valid;
    logic    rq_ready;
    rc_cpl_t rc_cpl;
    logic    rc_valid;
    logic    rc_ready;
    logic    dma_busy;
    logic    status_error_uncor;

    integer      main_seed;
    integer      cc_seed;
    integer      host_seed;
    int unsigned errors;
    int unsigned checks;
    int unsigned err_pulses;
    logic        aborted;
    logic        bp_on;
    data_t       ram_model [2 ** `RAM_AW];
    cc_cpl_t     exp_q [$];
    string       name_q [$];
    rq_req_t     host_q [$];

    pcie_core pcie_core_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // host memory as a fixed mix of the dword address
    function automatic data_t host_word(input host_addr_t addr);
        data_t a;
        a = data_t'(addr);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    function automatic data_t expect_ram(input ram_addr_t addr);
        return ram_model[addr];
    endfunction

    function automatic bar_addr_t reg_addr(input int off);
        return bar_addr_t'((1 << (`BAR_AW - 1)) | off);
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic timeout_hit(input string what);
        errors++;
        aborted = 1'b1;
        $display("timeout while waiting for %s at %0t", what, $time);
    endtask

    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        while (dma_busy !== level && !aborted) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                timeout_hit("dma_busy");
            end
        end
    endtask

    task automatic send_cq(input cq_op_e op_in, input bar_addr_t addr_in, input data_t data_in,
                           input tag_t tag_in);
        int n;
        n = 0;
        @(negedge clk);
        cq_req = '{op: op_in, addr: addr_in, data: data_in, tag: tag_in};
        cq_valid = 1'b1;
        while (!cq_ready && !aborted) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                timeout_hit("cq_ready");
            end
        end
        // handshake completes on the posedge in between
        @(negedge clk);
        cq_valid = 1'b0;
    endtask

    task automatic mmio_write(input bar_addr_t addr, input data_t data);
        if (!addr[`BAR_AW-1]) begin
            ram_model[addr[`RAM_AW-1:0]] = data;
        end
        send_cq(CQ_WRITE, addr, data, tag_t'($random(main_seed)));
    endtask

    task automatic mmio_read(input string name, input bar_addr_t addr, input data_t expected);
        cc_cpl_t want;
        want.tag = tag_t'($random(main_seed));
        want.data = expected;
        exp_q.push_back(want);
        name_q.push_back(name);
        send_cq(CQ_READ, addr, '0, want.tag);
    endtask

    task automatic read_range(input string name, input ram_addr_t first, input int count);
        ram_addr_t a;
        for (int i = 0; i < count; i++) begin
            a = first + ram_addr_t'(i);
            mmio_read(name, {1'b0, a}, expect_ram(a));
        end
    endtask

    // RAM[dst+i] takes host_word(src+i)
    task automatic apply_dma(input host_addr_t src, input ram_addr_t dst, input int len);
        for (int i = 0; i < len; i++) begin
            ram_model[dst + ram_addr_t'(i)] = host_word(src + host_addr_t'(i));
        end
    endtask

    task automatic start_dma(input string name, input host_addr_t src, input ram_addr_t dst,
                             input len_t len);
        mmio_write(reg_addr(`REG_SRC), data_t'(src));
        mmio_write(reg_addr(`REG_DST), data_t'(dst));
        mmio_write(reg_addr(`REG_LEN), data_t'(len));
        mmio_read({name, " src"}, reg_addr(`REG_SRC), data_t'(src));
        mmio_read({name, " dst"}, reg_addr(`REG_DST), data_t'(dst));
        mmio_read({name, " len"}, reg_addr(`REG_LEN), data_t'(len));
        mmio_write(reg_addr(`REG_CTRL), data_t'(1));
        wait_busy(1'b1);
    endtask

    // random back-pressure spans with hold check and in-order compare on cc
    initial begin : cc_monitor
        int      span;
        logic    held;
        cc_cpl_t held_cpl;
        cc_cpl_t want;
        string   name;
        cc_seed = SEED + 1;
        cc_ready = 1'b1;
        span = 0;
        held = 1'b0;
        forever begin
            @(negedge clk);
            if (held) begin
                check_value("cc hold valid", 64'd1, {63'd0, cc_valid});
                check_value("cc hold payload", 64'(held_cpl), 64'(cc_cpl));
            end
            if (span == 0) begin
                cc_ready = bp_on ? ({$random(cc_seed)} % 2 == 0) : 1'b1;
                span = bp_on ? 1 + {$random(cc_seed)} % 5 : 1;
            end
            span--;
            held = cc_valid && !cc_ready;
            held_cpl = cc_cpl;
            if (cc_valid && cc_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("unexpected completion with tag %0d at %0t", cc_cpl.tag, $time);
                end else begin
                    want = exp_q.pop_front();
                    name = name_q.pop_front();
                    check_value({name, " tag"}, 64'(want.tag), 64'(cc_cpl.tag));
                    check_value({name, " data"}, 64'(want.data), 64'(cc_cpl.data));
                end
            end
        end
    end

    // host answers read requests in random order with gaps
    initial begin : host_model
        int      idx;
        logic    sent;
        rq_req_t req;
        host_seed = SEED + 2;
        rq_ready = 1'b1;
        rc_valid = 1'b0;
        rc_cpl = '0;
        sent = 1'b0;
        forever begin
            @(negedge clk);
            if (status_error_uncor) begin
                err_pulses++;
            end
            if (sent) begin
                rc_valid = 1'b0;
            end
            // only requests taken on earlier edges may complete
            if (!rc_valid && host_q.size() > 0 && {$random(host_seed)} % 3 != 0) begin
                idx = {$random(host_seed)} % host_q.size();
                req = host_q[idx];
                host_q.delete(idx);
                rc_cpl = '{tag: req.tag, data: host_word(req.addr)};
                rc_valid = 1'b1;
            end
            sent = rc_valid && rc_ready;
            rq_ready = ({$random(host_seed)} % 4 != 0);
            if (rq_valid && rq_ready) begin
                host_q.push_back(rq_req);
            end
        end
    end

    initial begin : stimulus
        int         n;
        ram_addr_t  a;
        host_addr_t src;
        rq_req_t    bad;
        main_seed = SEED;
        errors = 0;
        checks = 0;
        err_pulses = 0;
        aborted = 1'b0;
        bp_on = 1'b0;
        rst_n = 1'b0;
        cq_valid = 1'b0;
        cq_req = '0;
        repeat (2) @(negedge clk);

        // outputs in their reset state
        check_value("reset cc_valid", 64'd0, 64'(cc_valid));
        check_value("reset rq_valid", 64'd0, 64'(rq_valid));
        check_value("reset dma_busy", 64'd0, 64'(dma_busy));
        check_value("reset error", 64'd0, 64'(status_error_uncor));
        check_value("reset cq_ready", 64'd1, 64'(cq_ready));
        check_value("reset rc_ready", 64'd1, 64'(rc_ready));
        rst_n = 1'b1;

        // known RAM contents before random writes and read-back
        for (int i = 0; i < 256; i++) begin
            mmio_write(bar_addr_t'(i), data_t'($random(main_seed)));
        end
        for (int i = 0; i < 32; i++) begin
            a = ram_addr_t'($random(main_seed));
            mmio_write({1'b0, a}, data_t'($random(main_seed)));
        end
        for (int i = 0; i < 32; i++) begin
            a = ram_addr_t'($random(main_seed));
            mmio_read("mmio readback", {1'b0, a}, expect_ram(a));
        end

        // register readback, CTRL busy flag and a 40 dword DMA
        src = host_addr_t'($random(main_seed));
        start_dma("dma regs", src, ram_addr_t'(8'h40), len_t'(40));
        mmio_read("ctrl busy", reg_addr(`REG_CTRL), data_t'(1));
        wait_busy(1'b0);
        mmio_read("ctrl idle", reg_addr(`REG_CTRL), data_t'(0));
        apply_dma(src, ram_addr_t'(8'h40), 40);
        read_range("dma data", ram_addr_t'(8'h40), 40);

        // completion whose tag was never issued
        bad.tag = tag_t'(5);
        bad.addr = '0;
        host_q.push_back(bad);
        n = 0;
        while (err_pulses == 0 && !aborted) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                timeout_hit("status_error_uncor");
            end
        end

        // MMIO below 0x80 while a DMA fills 0xa0 and up
        src = host_addr_t'($random(main_seed));
        start_dma("dma2 regs", src, ram_addr_t'(8'ha0), len_t'(24));
        for (int i = 0; i < 12; i++) begin
            a = ram_addr_t'({$random(main_seed)} % 128);
            mmio_write({1'b0, a}, data_t'($random(main_seed)));
            mmio_read("mmio during dma", {1'b0, a}, expect_ram(a));
        end
        wait_busy(1'b0);
        apply_dma(src, ram_addr_t'(8'ha0), 24);

        // whole RAM against the model under cc back-pressure
        bp_on = 1'b1;
        read_range("full readback", ram_addr_t'(0), 256);
        n = 0;
        while (exp_q.size() != 0 && !aborted) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                timeout_hit("outstanding completions");
            end
        end
        bp_on = 1'b0;

        check_value("host queue empty", 64'd0, 64'(host_q.size()));
        check_value("error pulses", 64'd1, 64'(err_pulses));
        errors += pcie_core_inst.dma_read_engine_inst.pcie_core_sva_inst.fail_count;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- pcie_core.f
+incdir+hdl
hdl/pcie_core_pkg.sv
hdl/bar_ram.sv
hdl/mem_arbiter.sv
hdl/cq_completer.sv
hdl/dma_read_engine.sv
hdl/pcie_core.sv
verification/pcie_core_sva.sv
verification/tb_pcie_core.sv

//--- Makefile
# Verilator build and run for the PCIe endpoint application core

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_pcie_core
FILELIST  := pcie_core.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard hdl/*.sv hdl/*.svh verification/*.sv)
PASS_MSG  := TESTS PASSED

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
